// File: Makefile
SIM        ?= verilator
SIM_FLAGS  ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing
TOP        ?= trap_unit_tb
FILELIST   ?= filelist.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(SIM) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(SIM) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Simulation FAILED" $(LOG); then exit 1; fi
	@grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: filelist.f
verilog/trap_pkg.sv
verilog/machine_timer.sv
verilog/trap_csr_file.sv
verilog/axil_reg_port.sv
verilog/trap_sequencer.sv
verilog/trap_unit_top.sv
tb/trap_unit_tb.sv

// File: tb/trap_stim.txt
// op addr/pc data expected; op 1 write, 2 read and compare, 3 trap (data = kind)
// op 4 set MIE and wait for irq, 5 no redirect, 6 mret then held ecall, 0 end
1 00000010 00000203 00000000
2 00000010 00000000 00000200
1 00000014 12345678 00000000
2 00000014 00000000 00000000
1 00000018 deadbeef 00000000
2 00000018 00000000 00000000
2 00000040 00000000 00000000
1 0000001c 00000008 00000000
3 00000040 00000000 00000200
2 00000014 00000000 00000040
2 00000018 00000000 0000000b
2 0000001c 00000000 00000080
3 00000080 00000001 00000200
2 00000018 00000000 00000003
2 00000014 00000000 00000080
2 0000001c 00000000 00000000
1 0000001c 00000080 00000000
3 00000000 00000002 00000080
2 0000001c 00000000 00000088
1 0000001c 00000000 00000000
1 0000000c 00000000 00000000
1 00000008 00000010 00000000
4 00000100 00000008 00000200
2 00000018 00000000 80000007
2 00000014 00000000 00000100
2 0000001c 00000000 00000080
5 00000000 00000000 00000000
6 00000180 00000100 00000200
2 00000018 00000000 0000000b
2 00000014 00000000 00000180
2 0000001c 00000000 00000080
0 00000000 00000000 00000000

// File: tb/trap_unit_tb.sv
// ---------------------------------------
// trap unit testbench
// replays the stimulus list of bus accesses,
// trap requests and timer interrupt checks
// ---------------------------------------
module trap_unit_tb;

    localparam int TIMEOUT = 200;  // cycles per wait
    localparam int MAX_OPS = 64;

    logic                clk = 1'b0;
    logic                rst_n;
    trap_pkg::trap_req_t trap_req;
    trap_pkg::xlen_t     cur_pc;
    trap_pkg::redirect_t redirect;
    logic                busy;
    trap_pkg::axil_req_t axil_req;
    trap_pkg::axil_rsp_t axil_rsp;

    // four words per line for op, addr or pc, data and expected
    trap_pkg::xlen_t stim [0:4*MAX_OPS-1];
    int              err_cnt  = 0;
    int              pass_cnt = 0;
    int              fail_cnt = 0;

    trap_unit_top #(
        .TICK_DIV (1)
    ) trap_unit_top_i (
        .clk_i      (clk),
        .rst_ni     (rst_n),
        .trap_req_i (trap_req),
        .cur_pc_i   (cur_pc),
        .redirect_o (redirect),
        .busy_o     (busy),
        .axil_req_i (axil_req),
        .axil_rsp_o (axil_rsp)
    );

    always #4 clk = ~clk;

    task automatic check_eq(input trap_pkg::xlen_t actual, input trap_pkg::xlen_t expected,
                            input string what);
        if (actual !== expected) begin
            $display("[FAIL] %0t: %s, got %08h, expected %08h", $time, what, actual, expected);
            err_cnt++;
        end
    endtask

    task automatic report_timeout(input string what);
        $display("timeout after %0d cycles waiting for %s at time %0t", TIMEOUT, what, $time);
        err_cnt++;
    endtask

    task automatic bus_write(input trap_pkg::xlen_t addr, input trap_pkg::xlen_t data);
        int n;
        @(posedge clk);
        axil_req.awvalid <= 1'b1;
        axil_req.awaddr  <= addr;
        axil_req.wvalid  <= 1'b1;
        axil_req.wdata   <= data;
        axil_req.wstrb   <= 4'hF;
        n = 0;
        @(negedge clk);
        while (!axil_rsp.awready && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (n == TIMEOUT) begin
            report_timeout("write handshake");
        end else begin
            check_eq(32'(axil_rsp.wready), 32'd1, "wready with awready");
        end
        @(posedge clk);  // address and data taken here
        axil_req.awvalid <= 1'b0;
        axil_req.wvalid  <= 1'b0;
        axil_req.bready  <= 1'b1;
        n = 0;
        @(negedge clk);
        while (!axil_rsp.bvalid && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (n == TIMEOUT) begin
            report_timeout("write response");
        end else begin
            check_eq(32'(axil_rsp.bresp), 32'd0, "bresp");
        end
        @(posedge clk);
        axil_req.bready <= 1'b0;
    endtask

    task automatic bus_read(input trap_pkg::xlen_t addr, output trap_pkg::xlen_t data);
        int n;
        @(posedge clk);
        axil_req.arvalid <= 1'b1;
        axil_req.araddr  <= addr;
        n = 0;
        @(negedge clk);
        while (!axil_rsp.arready && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (n == TIMEOUT) report_timeout("read handshake");
        @(posedge clk);
        axil_req.arvalid <= 1'b0;
        axil_req.rready  <= 1'b1;
        n = 0;
        @(negedge clk);
        while (!axil_rsp.rvalid && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (n == TIMEOUT) begin
            report_timeout("read data");
        end else begin
            check_eq(32'(axil_rsp.rresp), 32'd0, "rresp");
        end
        data = axil_rsp.rdata;
        @(posedge clk);
        axil_req.rready <= 1'b0;
    endtask

    // returns right after the accept edge with valid still high
    task automatic raise_request(input trap_pkg::xlen_t pc, input trap_pkg::trap_kind_e kind);
        int n;
        @(posedge clk);
        trap_req.valid <= 1'b1;
        trap_req.kind  <= kind;
        trap_req.pc    <= pc;
        n = 0;
        @(negedge clk);
        while (busy && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (n == TIMEOUT) report_timeout("request accept");
        @(posedge clk);
    endtask

    task automatic wait_redirect(input trap_pkg::xlen_t target, input logic check_busy,
                                 input string what);
        int n;
        n = 0;
        @(negedge clk);
        while (!redirect.valid && n < TIMEOUT) begin
            if (check_busy) check_eq(32'(busy), 32'd1, {"busy_o before ", what});
            @(negedge clk);
            n++;
        end
        if (n == TIMEOUT) begin
            report_timeout(what);
        end else begin
            check_eq(redirect.target, target, {what, " target"});
            check_eq(32'(busy), 32'd1, {"busy_o during ", what});
            @(negedge clk);
            check_eq(32'(redirect.valid), 32'd0, {what, " pulse width"});
            check_eq(32'(busy), 32'd0, {"busy_o after ", what});
        end
    endtask

    task automatic expect_quiet();
        for (int k = 0; k < TIMEOUT; k++) begin
            @(negedge clk);
            if (redirect.valid) begin
                $display("unexpected redirect to %08h at time %0t", redirect.target, $time);
                err_cnt++;
            end
        end
    endtask

    initial begin
        trap_pkg::xlen_t op;
        trap_pkg::xlen_t addr;
        trap_pkg::xlen_t data;
        trap_pkg::xlen_t exp_val;
        trap_pkg::xlen_t rd;
        int              errs_before;
        rst_n    <= 1'b0;
        trap_req <= '0;
        cur_pc   <= '0;
        axil_req <= '0;
        $readmemh("tb/trap_stim.txt", stim);
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        for (int i = 0; i < MAX_OPS; i++) begin
            op      = stim[4*i];
            addr    = stim[4*i+1];
            data    = stim[4*i+2];
            exp_val = stim[4*i+3];
            if (op == 0 || $isunknown(op)) break;  // end marker
            errs_before = err_cnt;
            case (op)
                32'd1: bus_write(addr, data);
                32'd2: begin
                    bus_read(addr, rd);
                    check_eq(rd, exp_val, $sformatf("read of offset %02h", addr));
                end
                32'd3: begin
                    raise_request(addr, trap_pkg::trap_kind_e'(data[1:0]));
                    trap_req.valid <= 1'b0;
                    wait_redirect(exp_val, 1'b1, "trap redirect");
                end
                32'd4: begin
                    @(posedge clk);
                    cur_pc <= addr;  // pc the core resumes at
                    bus_write(trap_pkg::REG_MSTATUS, data);
                    wait_redirect(exp_val, 1'b0, "interrupt redirect");
                end
                32'd5: expect_quiet();
                32'd6: begin
                    // ecall is held during the mret and then meets the pending irq
                    raise_request(32'h0, trap_pkg::MRET);
                    trap_req.kind <= trap_pkg::ECALL;
                    trap_req.pc   <= addr;
                    wait_redirect(data, 1'b1, "mret redirect");
                    @(posedge clk);
                    trap_req.valid <= 1'b0;
                    wait_redirect(exp_val, 1'b1, "held ecall redirect");
                end
                default: begin
                    $display("unknown opcode %0h on stimulus line %0d", op, i);
                    err_cnt++;
                end
            endcase
            if (err_cnt == errs_before) begin
                pass_cnt++;
                $display("test %0d op %0h addr %08h: ok", i, op, addr);
            end else begin
                fail_cnt++;
                $display("test %0d op %0h addr %08h: failed", i, op, addr);
            end
        end
        $display("tests passed: %0d, tests failed: %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0 && pass_cnt > 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// File: verilog/axil_reg_port.sv
// ---------------------------------------
// AXI4-Lite register port
// write strobe to timer and CSR file,
// registered read mux over the map
// ---------------------------------------
module axil_reg_port (
    input  logic                clk_i,
    input  logic                rst_ni,
    input  trap_pkg::axil_req_t axil_req_i,
    input  logic [63:0]         mtime_i,
    input  logic [63:0]         mtimecmp_i,
    input  trap_pkg::xlen_t     mtvec_i,
    input  trap_pkg::xlen_t     mepc_i,
    input  trap_pkg::xlen_t     mcause_i,
    input  trap_pkg::xlen_t     mstatus_i,
    output trap_pkg::axil_rsp_t axil_rsp_o,
    output logic                wr_en_o,
    output trap_pkg::xlen_t     wr_addr_o,
    output trap_pkg::xlen_t     wr_data_o,
    output logic [3:0]          wr_strb_o
);

    logic            bvalid_q;
    logic            rvalid_q;
    trap_pkg::xlen_t rdata_q;
    trap_pkg::xlen_t rd_mux;
    logic            wr_hs;
    logic            rd_hs;

    // address and data taken together
    assign wr_hs = axil_req_i.awvalid && axil_req_i.wvalid && !bvalid_q;
    assign rd_hs = axil_req_i.arvalid && !rvalid_q;

    assign wr_en_o   = wr_hs;
    assign wr_addr_o = axil_req_i.awaddr;
    assign wr_data_o = axil_req_i.wdata;
    assign wr_strb_o = axil_req_i.wstrb;

    always_comb begin
        case (axil_req_i.araddr)
            trap_pkg::REG_MTIME_LO:    rd_mux = mtime_i[31:0];
            trap_pkg::REG_MTIME_HI:    rd_mux = mtime_i[63:32];
            trap_pkg::REG_MTIMECMP_LO: rd_mux = mtimecmp_i[31:0];
            trap_pkg::REG_MTIMECMP_HI: rd_mux = mtimecmp_i[63:32];
            trap_pkg::REG_MTVEC:       rd_mux = mtvec_i;
            trap_pkg::REG_MEPC:        rd_mux = mepc_i;
            trap_pkg::REG_MCAUSE:      rd_mux = mcause_i;
            trap_pkg::REG_MSTATUS:     rd_mux = mstatus_i;
            default:                   rd_mux = '0;  // unmapped
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            bvalid_q <= 1'b0;
            rvalid_q <= 1'b0;
        end else begin
            if (wr_hs) begin
                bvalid_q <= 1'b1;
            end else if (axil_req_i.bready) begin
                bvalid_q <= 1'b0;
            end
            if (rd_hs) begin
                rvalid_q <= 1'b1;
            end else if (axil_req_i.rready) begin
                rvalid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (rd_hs) begin
            rdata_q <= rd_mux;
        end
    end

    always_comb begin
        axil_rsp_o         = '0;  // OKAY responses
        axil_rsp_o.awready = wr_hs;
        axil_rsp_o.wready  = wr_hs;
        axil_rsp_o.bvalid  = bvalid_q;
        axil_rsp_o.arready = !rvalid_q;
        axil_rsp_o.rvalid  = rvalid_q;
        axil_rsp_o.rdata   = rdata_q;
    end

    a_bvalid_hold : assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        bvalid_q && !axil_req_i.bready |=> bvalid_q
    );

endmodule

// File: verilog/machine_timer.sv
// ---------------------------------------
// machine timer
// prescaled 64-bit mtime, mtimecmp compare
// and registered timer-pending flag
// ---------------------------------------
module machine_timer #(
    parameter int unsigned TICK_DIV = 1
) (
    input  logic            clk_i,
    input  logic            rst_ni,
    input  logic            wr_en_i,
    input  trap_pkg::xlen_t wr_addr_i,
    input  trap_pkg::xlen_t wr_data_i,
    input  logic [3:0]      wr_strb_i,
    output logic [63:0]     mtime_o,
    output logic [63:0]     mtimecmp_o,
    output logic            pending_o
);

    localparam int unsigned PW = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;

    logic [PW-1:0] presc_q;
    logic          tick;
    logic [63:0]   mtime_q;
    logic [63:0]   mtimecmp_q;
    logic          pending_q;

    assign tick = (presc_q == PW'(TICK_DIV - 1));

    always_ff @(posedge clk_i) begin
        if (!rst_ni || tick) begin
            presc_q <= '0;
        end else begin
            presc_q <= presc_q + 1'b1;
        end
    end

    // bus write wins over the increment
    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            mtime_q <= '0;
        end else if (wr_en_i && wr_addr_i == trap_pkg::REG_MTIME_LO) begin
            mtime_q[31:0] <= trap_pkg::apply_strb(mtime_q[31:0], wr_data_i, wr_strb_i);
        end else if (wr_en_i && wr_addr_i == trap_pkg::REG_MTIME_HI) begin
            mtime_q[63:32] <= trap_pkg::apply_strb(mtime_q[63:32], wr_data_i, wr_strb_i);
        end else if (tick) begin
            mtime_q <= mtime_q + 64'd1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            mtimecmp_q <= '1;  // far future, nothing pending
        end else if (wr_en_i && wr_addr_i == trap_pkg::REG_MTIMECMP_LO) begin
            mtimecmp_q[31:0] <= trap_pkg::apply_strb(mtimecmp_q[31:0], wr_data_i, wr_strb_i);
        end else if (wr_en_i && wr_addr_i == trap_pkg::REG_MTIMECMP_HI) begin
            mtimecmp_q[63:32] <= trap_pkg::apply_strb(mtimecmp_q[63:32], wr_data_i, wr_strb_i);
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            pending_q <= 1'b0;
        end else begin
            pending_q <= (mtime_q >= mtimecmp_q);
        end
    end

    assign mtime_o    = mtime_q;
    assign mtimecmp_o = mtimecmp_q;
    assign pending_o  = pending_q;

endmodule

// File: verilog/trap_csr_file.sv
// ---------------------------------------
// trap CSR file
// mtvec, mepc, mcause and mstatus storage,
// sequencer writes win over bus writes
// ---------------------------------------
module trap_csr_file #(
    parameter trap_pkg::xlen_t MTVEC_RESET = 32'h0000_0100
) (
    input  logic              clk_i,
    input  logic              rst_ni,
    input  trap_pkg::csr_wr_t seq_wr_i,
    input  logic              bus_wr_en_i,
    input  trap_pkg::xlen_t   bus_wr_addr_i,
    input  trap_pkg::xlen_t   bus_wr_data_i,
    input  logic [3:0]        bus_wr_strb_i,
    output trap_pkg::xlen_t   mtvec_o,
    output trap_pkg::xlen_t   mepc_o,
    output trap_pkg::xlen_t   mcause_o,
    output trap_pkg::xlen_t   mstatus_o
);

    trap_pkg::xlen_t mtvec_q;
    trap_pkg::xlen_t mepc_q;
    trap_pkg::xlen_t mcause_q;
    logic            mie_q;
    logic            mpie_q;
    logic            bus_mtvec;
    logic            bus_mstatus;
    trap_pkg::xlen_t mtvec_new;
    trap_pkg::xlen_t mstatus_new;

    assign bus_mtvec   = bus_wr_en_i && bus_wr_addr_i == trap_pkg::REG_MTVEC;
    assign bus_mstatus = bus_wr_en_i && bus_wr_addr_i == trap_pkg::REG_MSTATUS;
    assign mtvec_new   = trap_pkg::apply_strb(mtvec_q, bus_wr_data_i, bus_wr_strb_i);
    assign mstatus_new = trap_pkg::apply_strb(mstatus_o, bus_wr_data_i, bus_wr_strb_i);

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            mtvec_q  <= {MTVEC_RESET[31:2], 2'b00};
            mepc_q   <= '0;
            mcause_q <= '0;
            mie_q    <= 1'b0;
            mpie_q   <= 1'b0;
        end else begin
            if (bus_mtvec) begin
                mtvec_q <= {mtvec_new[31:2], 2'b00};  // direct mode only
            end
            if (seq_wr_i.en && seq_wr_i.sel == trap_pkg::MEPC) begin
                mepc_q <= seq_wr_i.data;
            end
            if (seq_wr_i.en && seq_wr_i.sel == trap_pkg::MCAUSE) begin
                mcause_q <= seq_wr_i.data;
            end
            if (seq_wr_i.en && seq_wr_i.sel == trap_pkg::MSTATUS) begin
                mie_q  <= seq_wr_i.data[trap_pkg::MSTATUS_MIE];
                mpie_q <= seq_wr_i.data[trap_pkg::MSTATUS_MPIE];
            end else if (bus_mstatus) begin
                mie_q  <= mstatus_new[trap_pkg::MSTATUS_MIE];
                mpie_q <= mstatus_new[trap_pkg::MSTATUS_MPIE];
            end
        end
    end

    always_comb begin
        mstatus_o = '0;  // only MIE and MPIE are implemented
        mstatus_o[trap_pkg::MSTATUS_MIE]  = mie_q;
        mstatus_o[trap_pkg::MSTATUS_MPIE] = mpie_q;
    end

    assign mtvec_o  = mtvec_q;
    assign mepc_o   = mepc_q;
    assign mcause_o = mcause_q;

    a_sel_legal : assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        seq_wr_i.en |-> seq_wr_i.sel inside {trap_pkg::MEPC, trap_pkg::MSTATUS, trap_pkg::MCAUSE}
    );

endmodule

// File: verilog/trap_pkg.sv
// ---------------------------------------
// trap unit shared definitions
// bus and request structs, register map,
// cause codes and mstatus bit positions
// ---------------------------------------
package trap_pkg;

    typedef logic [31:0] xlen_t;

    typedef enum logic [1:0] {
        ECALL  = 2'd0,
        EBREAK = 2'd1,
        MRET   = 2'd2
    } trap_kind_e;

    typedef struct packed {
        logic       valid;
        trap_kind_e kind;
        xlen_t      pc;
    } trap_req_t;

    typedef struct packed {
        logic  valid;
        xlen_t target;
    } redirect_t;

    typedef enum logic [1:0] {
        MEPC    = 2'd0,
        MSTATUS = 2'd1,
        MCAUSE  = 2'd2
    } csr_sel_e;

    typedef struct packed {
        logic     en;
        csr_sel_e sel;
        xlen_t    data;
    } csr_wr_t;

    typedef struct packed {
        logic       awvalid;
        xlen_t      awaddr;
        logic       wvalid;
        xlen_t      wdata;
        logic [3:0] wstrb;
        logic       bready;
        logic       arvalid;
        xlen_t      araddr;
        logic       rready;
    } axil_req_t;

    typedef struct packed {
        logic       awready;
        logic       wready;
        logic       bvalid;
        logic [1:0] bresp;
        logic       arready;
        logic       rvalid;
        xlen_t      rdata;
        logic [1:0] rresp;
    } axil_rsp_t;

    // register map, byte offsets
    localparam xlen_t REG_MTIME_LO    = 32'h00;
    localparam xlen_t REG_MTIME_HI    = 32'h04;
    localparam xlen_t REG_MTIMECMP_LO = 32'h08;
    localparam xlen_t REG_MTIMECMP_HI = 32'h0C;
    localparam xlen_t REG_MTVEC       = 32'h10;
    localparam xlen_t REG_MEPC        = 32'h14;
    localparam xlen_t REG_MCAUSE      = 32'h18;
    localparam xlen_t REG_MSTATUS     = 32'h1C;

    localparam xlen_t CAUSE_ECALL_M    = 32'd11;
    localparam xlen_t CAUSE_BREAKPOINT = 32'd3;
    localparam xlen_t CAUSE_M_TIMER    = 32'h8000_0007; // interrupt bit set

    localparam int MSTATUS_MIE  = 3;
    localparam int MSTATUS_MPIE = 7;

    // byte-lane merge for partial bus writes
    function automatic xlen_t apply_strb(xlen_t old_val, xlen_t new_val, logic [3:0] strb);
        xlen_t res;
        res = old_val;
        for (int i = 0; i < 4; i++) begin
            if (strb[i]) begin
                res[8*i +: 8] = new_val[8*i +: 8];
            end
        end
        return res;
    endfunction

endpackage

// File: verilog/trap_sequencer.sv
// ---------------------------------------
// trap sequencer
// arbitrates ecall/ebreak, timer irq and mret,
// then writes mepc, mstatus, mcause in order
// and pulses the fetch redirect
// ---------------------------------------
module trap_sequencer (
    input  logic                clk_i,
    input  logic                rst_ni,
    input  trap_pkg::trap_req_t trap_req_i,
    input  trap_pkg::xlen_t     cur_pc_i,
    input  logic                timer_pending_i,
    input  trap_pkg::xlen_t     mstatus_i,
    input  trap_pkg::xlen_t     mtvec_i,
    input  trap_pkg::xlen_t     mepc_i,
    output trap_pkg::csr_wr_t   csr_wr_o,
    output trap_pkg::redirect_t redirect_o,
    output logic                busy_o
);

    typedef enum logic [5:0] {
        IDLE        = 6'b000001,
        W_MEPC      = 6'b000010,
        W_MSTATUS   = 6'b000100,
        W_MCAUSE    = 6'b001000,
        REDIRECT    = 6'b010000,
        MRET_STATUS = 6'b100000
    } state_e;

    state_e          state_q;
    logic            ret_q;     // redirect goes to mepc
    trap_pkg::xlen_t epc_q;
    trap_pkg::xlen_t cause_q;
    trap_pkg::xlen_t mstatus_trap;
    trap_pkg::xlen_t mstatus_ret;
    logic            take_sync;
    logic            take_irq;
    logic            take_mret;

    assign take_sync = trap_req_i.valid &&
                       (trap_req_i.kind == trap_pkg::ECALL ||
                        trap_req_i.kind == trap_pkg::EBREAK);
    assign take_irq  = timer_pending_i && mstatus_i[trap_pkg::MSTATUS_MIE];
    assign take_mret = trap_req_i.valid && trap_req_i.kind == trap_pkg::MRET;

    assign busy_o = (state_q != IDLE);

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            state_q <= IDLE;
            ret_q   <= 1'b0;
        end else begin
            case (state_q)
                IDLE: begin
                    // sync trap outranks the interrupt, mret comes last
                    if (take_sync || take_irq) begin
                        state_q <= W_MEPC;
                        ret_q   <= 1'b0;
                    end else if (take_mret) begin
                        state_q <= MRET_STATUS;
                        ret_q   <= 1'b1;
                    end
                end
                W_MEPC:      state_q <= W_MSTATUS;
                W_MSTATUS:   state_q <= W_MCAUSE;
                W_MCAUSE:    state_q <= REDIRECT;
                MRET_STATUS: state_q <= REDIRECT;
                REDIRECT:    state_q <= IDLE;
                default:     state_q <= IDLE;
            endcase
        end
    end

    // return pc and cause, captured on entry
    always_ff @(posedge clk_i) begin
        if (state_q == IDLE) begin
            if (take_sync) begin
                epc_q   <= trap_req_i.pc;
                cause_q <= (trap_req_i.kind == trap_pkg::EBREAK) ?
                           trap_pkg::CAUSE_BREAKPOINT : trap_pkg::CAUSE_ECALL_M;
            end else if (take_irq) begin
                epc_q   <= cur_pc_i;  // resume where the core stopped
                cause_q <= trap_pkg::CAUSE_M_TIMER;
            end
        end
    end

    always_comb begin
        mstatus_trap = mstatus_i;
        mstatus_trap[trap_pkg::MSTATUS_MPIE] = mstatus_i[trap_pkg::MSTATUS_MIE];
        mstatus_trap[trap_pkg::MSTATUS_MIE]  = 1'b0;
        mstatus_ret = mstatus_i;
        mstatus_ret[trap_pkg::MSTATUS_MIE]  = mstatus_i[trap_pkg::MSTATUS_MPIE];
        mstatus_ret[trap_pkg::MSTATUS_MPIE] = 1'b1;
    end

    always_comb begin
        csr_wr_o   = '{en: 1'b0, sel: trap_pkg::MEPC, data: '0};
        redirect_o = '0;
        case (state_q)
            W_MEPC:      csr_wr_o = '{en: 1'b1, sel: trap_pkg::MEPC, data: epc_q};
            W_MSTATUS:   csr_wr_o = '{en: 1'b1, sel: trap_pkg::MSTATUS, data: mstatus_trap};
            W_MCAUSE:    csr_wr_o = '{en: 1'b1, sel: trap_pkg::MCAUSE, data: cause_q};
            MRET_STATUS: csr_wr_o = '{en: 1'b1, sel: trap_pkg::MSTATUS, data: mstatus_ret};
            REDIRECT: begin
                redirect_o.valid  = 1'b1;
                redirect_o.target = ret_q ? mepc_i : mtvec_i;
            end
            default: ;
        endcase
    end

    // a single redirect per trap or return
    a_redirect_single : assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        redirect_o.valid |=> !redirect_o.valid
    );

    // the core must be stalled while CSRs change
    a_write_while_busy : assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        csr_wr_o.en |-> busy_o
    );

endmodule

// File: verilog/trap_unit_top.sv
// ---------------------------------------
// trap unit top
// bus port, machine timer, CSR file
// and trap sequencer
// ---------------------------------------
module trap_unit_top #(
    parameter int unsigned     TICK_DIV    = 1,
    parameter trap_pkg::xlen_t MTVEC_RESET = 32'h0000_0100
) (
    input  logic                clk_i,
    input  logic                rst_ni,
    input  trap_pkg::trap_req_t trap_req_i,
    input  trap_pkg::xlen_t     cur_pc_i,
    output trap_pkg::redirect_t redirect_o,
    output logic                busy_o,
    input  trap_pkg::axil_req_t axil_req_i,
    output trap_pkg::axil_rsp_t axil_rsp_o
);

    logic              wr_en;
    trap_pkg::xlen_t   wr_addr;
    trap_pkg::xlen_t   wr_data;
    logic [3:0]        wr_strb;
    logic [63:0]       mtime;
    logic [63:0]       mtimecmp;
    logic              timer_pending;
    trap_pkg::xlen_t   mtvec;
    trap_pkg::xlen_t   mepc;
    trap_pkg::xlen_t   mcause;
    trap_pkg::xlen_t   mstatus;
    trap_pkg::csr_wr_t csr_wr;

    axil_reg_port axil_reg_port_i (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .axil_req_i (axil_req_i),
        .mtime_i    (mtime),
        .mtimecmp_i (mtimecmp),
        .mtvec_i    (mtvec),
        .mepc_i     (mepc),
        .mcause_i   (mcause),
        .mstatus_i  (mstatus),
        .axil_rsp_o (axil_rsp_o),
        .wr_en_o    (wr_en),
        .wr_addr_o  (wr_addr),
        .wr_data_o  (wr_data),
        .wr_strb_o  (wr_strb)
    );

    machine_timer #(
        .TICK_DIV (TICK_DIV)
    ) machine_timer_i (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .wr_en_i    (wr_en),
        .wr_addr_i  (wr_addr),
        .wr_data_i  (wr_data),
        .wr_strb_i  (wr_strb),
        .mtime_o    (mtime),
        .mtimecmp_o (mtimecmp),
        .pending_o  (timer_pending)
    );

    trap_csr_file #(
        .MTVEC_RESET (MTVEC_RESET)
    ) trap_csr_file_i (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .seq_wr_i      (csr_wr),
        .bus_wr_en_i   (wr_en),
        .bus_wr_addr_i (wr_addr),
        .bus_wr_data_i (wr_data),
        .bus_wr_strb_i (wr_strb),
        .mtvec_o       (mtvec),
        .mepc_o        (mepc),
        .mcause_o      (mcause),
        .mstatus_o     (mstatus)
    );

    trap_sequencer trap_sequencer_i (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .trap_req_i      (trap_req_i),
        .cur_pc_i        (cur_pc_i),
        .timer_pending_i (timer_pending),
        .mstatus_i       (mstatus),
        .mtvec_i         (mtvec),
        .mepc_i          (mepc),
        .csr_wr_o        (csr_wr),
        .redirect_o      (redirect_o),
        .busy_o          (busy_o)
    );

endmodule
